/* src.f */
+incdir+hw
hw/mmem_pkg.sv
hw/mmem_dpram.sv
hw/mbus_alu.sv
hw/mmem_seq.sv
hw/mmem_top.sv
tests/mmem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the scratchpad testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module mmem_tb -f src.f --Mdir "$OBJ" -o mmem_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/mmem_sim" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$LOG"
   echo "Simulation run failed"
   exit 1
fi

cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
   echo "Simulation failed, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0

/* tests/mmem_tb.sv */
// Testbench that checks random scratchpad slice operations against a shadow memory.

`timescale 1ns/1ns

`include "mmem_settings.svh"

module mmem_tb;

   localparam int NUM_LOADS      = `MMEM_DEPTH;
   localparam int NUM_FIXED      = 40;
   localparam int NUM_SPACED     = 40;
   localparam int NUM_OVERRUN    = 3;
   localparam int NUM_OPS        = 3 * NUM_LOADS + NUM_FIXED + NUM_SPACED + 3 * NUM_OVERRUN;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 6 + 200;

   logic                clk_a = 1'b0;
   logic                reset;
   logic                op_valid;
   mmem_pkg::opcode_t   opcode;
   logic [`MMEM_AW-1:0] src_a;
   logic [`MMEM_AW-1:0] src_b;
   logic [`MMEM_AW-1:0] dst;
   logic [`MMEM_DW-1:0] imm;
   logic [`MMEM_DW-1:0] result;
   logic                result_valid;
   logic                busy;
   logic                overrun;

   logic [`MMEM_DW-1:0] shadow [0:`MMEM_DEPTH-1]; // Model of the scratchpad.
   mmem_pkg::opcode_t   exp_op  [$];
   logic [`MMEM_AW-1:0] exp_sa  [$];
   logic [`MMEM_AW-1:0] exp_sb  [$];
   logic [`MMEM_AW-1:0] exp_dst [$];
   logic [`MMEM_DW-1:0] exp_imm [$];

   integer seed        = 32'hdd71_c8cd;
   int     errors      = 0;
   int     checks      = 0;
   int     cycle_count = 0;
   int     last_accept = -100; // Edge of the last accepted strobe.

   mmem_top u_dut
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .op_valid     (op_valid),
      .opcode       (opcode),
      .src_a        (src_a),
      .src_b        (src_b),
      .dst          (dst),
      .imm          (imm),
      .result       (result),
      .result_valid (result_valid),
      .busy         (busy),
      .overrun      (overrun)
   );

   always #4 clk_a = ~clk_a;

   always @(posedge clk_a)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // ******************************
   // Reference model and helpers
   // ******************************
   function automatic logic [`MMEM_DW-1:0] ref_result(input mmem_pkg::opcode_t op,
                                                      input logic [`MMEM_DW-1:0] a,
                                                      input logic [`MMEM_DW-1:0] b,
                                                      input logic [`MMEM_DW-1:0] im);
      case (op)
         mmem_pkg::op_load: return im;
         mmem_pkg::op_move: return a;
         mmem_pkg::op_add:  return a + b; // Modulo 2**32.
         mmem_pkg::op_sub:  return a - b;
         mmem_pkg::op_and:  return a & b;
         mmem_pkg::op_or:   return a | b;
         mmem_pkg::op_xor:  return a ^ b;
         mmem_pkg::op_read: return a;
         default:           return '0;
      endcase
   endfunction

   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic logic [`MMEM_AW-1:0] rand_addr();
      logic [31:0] r;
      r = rand_word();
      return r[`MMEM_AW-1:0];
   endfunction

   function automatic mmem_pkg::opcode_t rand_alu_op();
      logic [31:0] k;
      k = rand_word() % 32'd6;
      return mmem_pkg::opcode_t'(k[2:0] + 3'd1); // op_move to op_xor.
   endfunction

   task automatic check_value(input string name,
                              input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   // Driven at a falling edge so the strobe is sampled at the next rising edge.
   task automatic issue_op(input mmem_pkg::opcode_t op,
                           input logic [`MMEM_AW-1:0] sa,
                           input logic [`MMEM_AW-1:0] sb,
                           input logic [`MMEM_AW-1:0] d,
                           input logic [`MMEM_DW-1:0] im,
                           input bit accepted);
      op_valid = 1'b1;
      opcode   = op;
      src_a    = sa;
      src_b    = sb;
      dst      = d;
      imm      = im;
      if (accepted)
      begin
         exp_op.push_back(op);
         exp_sa.push_back(sa);
         exp_sb.push_back(sb);
         exp_dst.push_back(d);
         exp_imm.push_back(im);
         last_accept = cycle_count + 1;
      end
      @(negedge clk_a);
      op_valid = 1'b0;
   endtask

   task automatic wait_gap(input int cycles);
      repeat (cycles - 1) @(negedge clk_a);
   endtask

   task automatic wait_idle();
      while (busy) @(negedge clk_a);
   endtask

   // ******************************
   // Result comparison
   // ******************************
   always @(negedge clk_a)
   begin
      mmem_pkg::opcode_t   op;
      logic [`MMEM_AW-1:0] sa;
      logic [`MMEM_AW-1:0] sb;
      logic [`MMEM_AW-1:0] d;
      logic [`MMEM_DW-1:0] im;
      logic [`MMEM_DW-1:0] expected;
      if (!reset && result_valid)
      begin
         if (exp_op.size() == 0)
         begin
            errors++;
            $display("A result appeared at %0t with no operation outstanding.", $time);
         end
         else
         begin
            op       = exp_op.pop_front();
            sa       = exp_sa.pop_front();
            sb       = exp_sb.pop_front();
            d        = exp_dst.pop_front();
            im       = exp_imm.pop_front();
            expected = ref_result(op, shadow[sa], shadow[sb], im);
            check_value("result", expected, result);
            if (op != mmem_pkg::op_read)
            begin
               shadow[d] = expected; // Write-back lands at the next edge.
            end
         end
      end
   end

   // Busy for three cycles after each accepted strobe and result_valid in the third.
   always @(negedge clk_a)
   begin
      int since;
      if (!reset)
      begin
         since = cycle_count - last_accept;
         check_value("busy", 32'((since >= 0) && (since < 3)), 32'(busy));
         check_value("result_valid", 32'(since == 2), 32'(result_valid));
         if (last_accept < 0)
         begin
            check_value("overrun", 32'd0, 32'(overrun));
         end
      end
   end

   // ******************************
   // Stimulus
   // ******************************
   initial
   begin
      logic [`MMEM_AW-1:0] a_sel;
      logic [`MMEM_AW-1:0] b_sel;
      logic [`MMEM_AW-1:0] d_sel;
      logic [`MMEM_AW-1:0] prev_dst;
      int                  gap;
      reset    = 1'b1;
      op_valid = 1'b0;
      opcode   = mmem_pkg::op_load;
      src_a    = '0;
      src_b    = '0;
      dst      = '0;
      imm      = '0;
      prev_dst = '0;
      repeat (16) @(negedge clk_a);
      reset = 1'b0;
      repeat (5) @(negedge clk_a); // Idle with all status low.

      for (int i = 0; i < NUM_LOADS; i++)
      begin
         issue_op(mmem_pkg::op_load, rand_addr(), rand_addr(), i[`MMEM_AW-1:0], rand_word(), 1'b1);
         wait_gap(4);
      end
      for (int i = 0; i < NUM_LOADS; i++)
      begin
         issue_op(mmem_pkg::op_read, i[`MMEM_AW-1:0], rand_addr(), rand_addr(), rand_word(), 1'b1);
         wait_gap(4);
      end

      for (int i = 0; i < NUM_FIXED; i++)
      begin
         a_sel = (i % 2 == 0) ? prev_dst : rand_addr(); // Uses the word just written.
         b_sel = rand_addr();
         d_sel = (i % 5 == 0) ? a_sel : rand_addr();
         issue_op(rand_alu_op(), a_sel, b_sel, d_sel, rand_word(), 1'b1);
         prev_dst = d_sel;
         wait_gap(4);
      end

      for (int i = 0; i < NUM_SPACED; i++)
      begin
         gap = 4 + int'(rand_word() % 32'd7);
         issue_op(rand_alu_op(), rand_addr(), rand_addr(), rand_addr(), rand_word(), 1'b1);
         wait_gap(gap);
      end
      wait_idle();
      check_value("overrun", 32'd0, 32'(overrun));

      // Strobes one to three cycles after an accepted one are dropped.
      for (int g = 1; g <= NUM_OVERRUN; g++)
      begin
         d_sel = rand_addr();
         issue_op(rand_alu_op(), rand_addr(), rand_addr(), rand_addr(), rand_word(), 1'b1);
         wait_gap(g);
         issue_op(mmem_pkg::op_load, rand_addr(), rand_addr(), d_sel, rand_word(), 1'b0);
         check_value("overrun", 32'd1, 32'(overrun));
         wait_idle();
         issue_op(mmem_pkg::op_read, d_sel, rand_addr(), rand_addr(), rand_word(), 1'b1);
         wait_gap(4);
      end
      check_value("overrun", 32'd1, 32'(overrun));

      reset = 1'b1;
      repeat (4) @(negedge clk_a);
      reset = 1'b0;
      check_value("overrun", 32'd0, 32'(overrun));

      for (int i = 0; i < NUM_LOADS; i++)
      begin
         issue_op(mmem_pkg::op_read, i[`MMEM_AW-1:0], rand_addr(), rand_addr(), rand_word(), 1'b1);
         wait_gap(4);
      end
      wait_idle();
      @(negedge clk_a);
      if (exp_op.size() != 0)
      begin
         errors++;
         $display("%0d accepted operations never produced a result.", exp_op.size());
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* hw/mmem_top.sv */
// Scratchpad slice top level joining the sequencer, the dual-port RAM and the ALU.

`timescale 1ns/1ns

`include "mmem_settings.svh"

module mmem_top
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                op_valid,
   input  mmem_pkg::opcode_t   opcode,
   input  logic [`MMEM_AW-1:0] src_a,
   input  logic [`MMEM_AW-1:0] src_b,
   input  logic [`MMEM_AW-1:0] dst,
   input  logic [`MMEM_DW-1:0] imm,
   output logic [`MMEM_DW-1:0] result,
   output logic                result_valid,
   output logic                busy,
   output logic                overrun
);

   mmem_pkg::opcode_t   op_q;
   logic [`MMEM_DW-1:0] imm_q;
   logic [`MMEM_AW-1:0] address_a;
   logic [`MMEM_AW-1:0] address_b;
   logic                rden_a;
   logic                rden_b;
   logic                wren_a;
   logic [`MMEM_DW-1:0] q_a;
   logic [`MMEM_DW-1:0] q_b;

   // ******************************
   // Sequencer
   // ******************************
   mmem_seq u_seq
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .op_valid     (op_valid),
      .opcode       (opcode),
      .src_a        (src_a),
      .src_b        (src_b),
      .dst          (dst),
      .imm          (imm),
      .op_q         (op_q),
      .imm_q        (imm_q),
      .address_a    (address_a),
      .address_b    (address_b),
      .rden_a       (rden_a),
      .rden_b       (rden_b),
      .wren_a       (wren_a),
      .result_valid (result_valid),
      .busy         (busy),
      .overrun      (overrun)
   );

   // ******************************
   // Scratchpad and ALU
   // ******************************
   mmem_dpram u_ram
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (address_a),
      .address_b (address_b),
      .data_a    (result), // Write-back of the ALU register.
      .wren_a    (wren_a),
      .rden_a    (rden_a),
      .rden_b    (rden_b),
      .q_a       (q_a),
      .q_b       (q_b)
   );

   mbus_alu u_alu
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .opcode (op_q),
      .a      (q_a),
      .b      (q_b),
      .imm    (imm_q),
      .result (result)
   );

endmodule

/* hw/mmem_seq.sv */
// Sequencer that steps one host operation through read, execute and write-back.

`timescale 1ns/1ns

`include "mmem_settings.svh"

module mmem_seq
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                op_valid,
   input  mmem_pkg::opcode_t   opcode,
   input  logic [`MMEM_AW-1:0] src_a,
   input  logic [`MMEM_AW-1:0] src_b,
   input  logic [`MMEM_AW-1:0] dst,
   input  logic [`MMEM_DW-1:0] imm,
   output mmem_pkg::opcode_t   op_q,
   output logic [`MMEM_DW-1:0] imm_q,
   output logic [`MMEM_AW-1:0] address_a,
   output logic [`MMEM_AW-1:0] address_b,
   output logic                rden_a,
   output logic                rden_b,
   output logic                wren_a,
   output logic                result_valid,
   output logic                busy,
   output logic                overrun
);

   mmem_pkg::seq_state_t state;
   mmem_pkg::seq_state_t state_next;

   logic [`MMEM_AW-1:0] src_a_q;
   logic [`MMEM_AW-1:0] src_b_q;
   logic [`MMEM_AW-1:0] dst_q;
   logic                accept;

   assign accept = op_valid && (state == mmem_pkg::st_idle);

   // ******************************
   // State machine
   // ******************************
   always_comb
   begin
      state_next = state;
      case (state)
         mmem_pkg::st_idle:
         begin
            if (op_valid)
            begin
               state_next = mmem_pkg::st_read;
            end
         end
         mmem_pkg::st_read:
         begin
            state_next = mmem_pkg::st_exec;
         end
         mmem_pkg::st_exec:
         begin
            state_next = mmem_pkg::st_write;
         end
         default:
         begin
            state_next = mmem_pkg::st_idle; // Back from st_write.
         end
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= mmem_pkg::st_idle;
      end
      else
      begin
         state <= state_next;
      end
   end

   // ******************************
   // Operation capture
   // ******************************
   always_ff @(posedge clk_a)
   begin
      if (accept)
      begin
         op_q    <= opcode;
         imm_q   <= imm;
         src_a_q <= src_a;
         src_b_q <= src_b;
         dst_q   <= dst;
      end
   end

   // Strobes seen while busy are dropped and latched here until reset.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         overrun <= 1'b0;
      end
      else if (op_valid && (state != mmem_pkg::st_idle))
      begin
         overrun <= 1'b1;
      end
   end

   // ******************************
   // RAM controls and status
   // ******************************
   assign address_a    = (state == mmem_pkg::st_write) ? dst_q : src_a_q;
   assign address_b    = src_b_q;
   assign rden_a       = (state == mmem_pkg::st_read);
   assign rden_b       = (state == mmem_pkg::st_read);
   assign wren_a       = (state == mmem_pkg::st_write) && (op_q != mmem_pkg::op_read);
   assign result_valid = (state == mmem_pkg::st_write); // ALU output is settled here.
   assign busy         = (state != mmem_pkg::st_idle);

endmodule

/* hw/mbus_alu.sv */
// Registered ALU combining the scratchpad read words or the immediate.

`timescale 1ns/1ns

`include "mmem_settings.svh"

module mbus_alu
(
   input  logic                clk_a,
   input  logic                reset,
   input  mmem_pkg::opcode_t   opcode,
   input  logic [`MMEM_DW-1:0] a,
   input  logic [`MMEM_DW-1:0] b,
   input  logic [`MMEM_DW-1:0] imm,
   output logic [`MMEM_DW-1:0] result
);

   logic [`MMEM_DW-1:0] alu_next;

   // ******************************
   // Function select
   // ******************************
   always_comb
   begin
      case (opcode)
         mmem_pkg::op_load:
         begin
            alu_next = imm;
         end
         mmem_pkg::op_move:
         begin
            alu_next = a;
         end
         mmem_pkg::op_add:
         begin
            alu_next = a + b; // Carry out is dropped.
         end
         mmem_pkg::op_sub:
         begin
            alu_next = a - b;
         end
         mmem_pkg::op_and:
         begin
            alu_next = a & b;
         end
         mmem_pkg::op_or:
         begin
            alu_next = a | b;
         end
         mmem_pkg::op_xor:
         begin
            alu_next = a ^ b;
         end
         mmem_pkg::op_read:
         begin
            alu_next = a; // Shown on the result port only.
         end
         default:
         begin
            alu_next = a;
         end
      endcase
   end

   // ******************************
   // Result register
   // ******************************
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         result <= '0;
      end
      else
      begin
         result <= alu_next; // Loaded every cycle.
      end
   end

endmodule

/* hw/mmem_dpram.sv */
// Dual-port synchronous scratchpad RAM with registered read ports.

`timescale 1ns/1ns

`include "mmem_settings.svh"

module mmem_dpram
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic [`MMEM_AW-1:0] address_a,
   input  logic [`MMEM_AW-1:0] address_b,
   input  logic [`MMEM_DW-1:0] data_a,
   input  logic                wren_a,
   input  logic                rden_a,
   input  logic                rden_b,
   output logic [`MMEM_DW-1:0] q_a,
   output logic [`MMEM_DW-1:0] q_b
);

   logic [`MMEM_DW-1:0] mem [0:`MMEM_DEPTH-1]; // Contents survive reset.

   // ******************************
   // Write port
   // ******************************
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         mem[address_a] <= data_a;
      end
   end

   // ******************************
   // Read ports
   // ******************************
   // A read in the same cycle as a write returns the old word.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= mem[address_a];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= mem[address_b]; // Source b always on port b.
      end
   end

endmodule

/* hw/mmem_pkg.sv */
// Opcode and sequencer state types shared by the scratchpad slice.

package mmem_pkg;

   // ******************************
   // Host opcodes
   // ******************************
   typedef enum logic [2:0]
   {
      op_load = 3'd0, // Result is the immediate.
      op_move = 3'd1, // Result is source a.
      op_add  = 3'd2, // Wraps modulo 2**32.
      op_sub  = 3'd3,
      op_and  = 3'd4,
      op_or   = 3'd5,
      op_xor  = 3'd6,
      op_read = 3'd7  // Source a without write-back.
   } opcode_t;

   // ******************************
   // Sequencer states
   // ******************************
   typedef enum logic [1:0]
   {
      st_idle  = 2'd0,
      st_read  = 2'd1, // RAM ports read both sources.
      st_exec  = 2'd2, // ALU registers its result.
      st_write = 2'd3  // Write-back and result strobe.
   } seq_state_t;

endpackage

/* hw/mmem_settings.svh */
// Sizing constants for the microcode scratchpad slice.

`ifndef MMEM_SETTINGS_SVH
`define MMEM_SETTINGS_SVH

// ******************************
// Scratchpad geometry
// ******************************

// Address width of both RAM ports.
`define MMEM_AW 5

// Width of one scratchpad word.
`define MMEM_DW 32

// Number of words, two to the power MMEM_AW.
`define MMEM_DEPTH 32

`endif
